//--- source/sat_pkg.sv
package sat_pkg;

    localparam int num_vars = 8;
    localparam int lvl_w    = 8;
    localparam int idx_w    = $clog2(num_vars);

    // byte addresses on the APB port
    localparam logic [7:0] addr_cmd      = 8'h00;
    localparam logic [7:0] addr_base_lvl = 8'h04;
    localparam logic [7:0] addr_clause   = 8'h08;
    localparam logic [7:0] addr_status   = 8'h0C;
    localparam logic [7:0] addr_var_base = 8'h10;

    typedef enum logic [1:0] {
        op_decide    = 2'd0,
        op_imply     = 2'd1,
        op_analyze   = 2'd2,
        op_backtrack = 2'd3
    } op_t;

    typedef struct packed {
        logic             assigned;
        logic             value;
        logic             decided;
        logic [lvl_w-1:0] lvl;
    } var_state_t;

    // lit_pol 1 selects the positive literal
    typedef struct packed {
        logic [num_vars-1:0] lit_mask;
        logic [num_vars-1:0] lit_pol;
    } clause_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic [21:0]      rsvd;
        op_t              op;
        logic [lvl_w-1:0] arg_lvl;
    } cmd_word_t;

    typedef struct packed {
        logic [20:0] rsvd;
        var_state_t  state;
    } var_word_t;

    typedef struct packed {
        logic [15:0] rsvd;
        clause_t     clause;
    } clause_word_t;

    // view is chosen by paddr
    typedef union packed {
        cmd_word_t    cmd;
        var_word_t    var_word;
        clause_word_t clause_word;
    } wdata_u;

    typedef struct packed {
        logic             valid;
        op_t              op;
        logic [lvl_w-1:0] arg_lvl;
    } cmd_t;

    typedef struct packed {
        logic [num_vars-1:0] var_we;
        var_state_t          var_data;
        logic                clause_we;
        clause_t             clause_data;
        logic                base_we;
        logic [lvl_w-1:0]    base_data;
    } load_t;

    typedef struct packed {
        logic [8:0]       rsvd;
        logic [lvl_w-1:0] cur_lvl;
        logic [lvl_w-1:0] bkt_lvl;
        logic             conflict;
        logic             no_free_var;
        logic             done_decide;
        logic             done_imply;
        logic             done_analyze;
        logic             done_backtrack;
        logic             imply_found;
    } status_t;

    function automatic logic is_var_addr(logic [7:0] a);
        return (a >= addr_var_base) && (a < addr_var_base + 8'(4 * num_vars)) && (a[1:0] == 2'b00);
    endfunction

    function automatic logic [idx_w-1:0] var_sel(logic [7:0] a);
        logic [7:0] off;
        off = a - addr_var_base;
        return off[idx_w+1:2];
    endfunction

    function automatic logic addr_mapped(logic [7:0] a);
        return (a == addr_cmd) || (a == addr_base_lvl) || (a == addr_clause) ||
               (a == addr_status) || is_var_addr(a);
    endfunction

endpackage

//--- source/apb_cmd_decode.sv
`timescale 1ns/1ps

module apb_cmd_decode (
    input  logic             clk,
    input  logic             rst,
    input  sat_pkg::apb_req_t apb_i,
    output sat_pkg::cmd_t     cmd_o,
    output sat_pkg::load_t    load_o,
    output logic             wr_ack_o,
    output logic             wr_err_o
);

    logic                         wr_setup;
    logic                         wr_done;
    logic                         bad_addr;
    logic [sat_pkg::num_vars-1:0] var_we;
    sat_pkg::wdata_u              wdata;

    assign wdata = apb_i.pwdata;

    assign wr_setup = apb_i.psel & ~apb_i.penable & apb_i.pwrite;

    // wr_ack_o is already high in the access cycle
    assign wr_done = apb_i.psel & apb_i.penable & apb_i.pwrite & wr_ack_o & ~wr_err_o;

    // status is read only
    assign bad_addr = ~sat_pkg::addr_mapped(apb_i.paddr) |
                      (apb_i.paddr == sat_pkg::addr_status);

    assign var_we = (wr_done && sat_pkg::is_var_addr(apb_i.paddr)) ?
                    (sat_pkg::num_vars'(1) << sat_pkg::var_sel(apb_i.paddr)) : '0;

    always_ff @(posedge clk) begin
        if (!rst) begin
            wr_ack_o <= 1'b0;
            wr_err_o <= 1'b0;
            cmd_o    <= '0;
            load_o   <= '0;
        end else begin
            wr_ack_o <= wr_setup;
            wr_err_o <= wr_setup & bad_addr;

            cmd_o.valid   <= wr_done & (apb_i.paddr == sat_pkg::addr_cmd);
            cmd_o.op      <= wdata.cmd.op;
            cmd_o.arg_lvl <= wdata.cmd.arg_lvl;

            load_o.var_we      <= var_we;
            load_o.var_data    <= wdata.var_word.state;
            load_o.clause_we   <= wr_done & (apb_i.paddr == sat_pkg::addr_clause);
            load_o.clause_data <= wdata.clause_word.clause;
            load_o.base_we     <= wr_done & (apb_i.paddr == sat_pkg::addr_base_lvl);
            load_o.base_data   <= apb_i.pwdata[sat_pkg::lvl_w-1:0];
        end
    end

endmodule

//--- source/var_state_bank.sv
`timescale 1ns/1ps

module var_state_bank (
    input  logic                                          clk,
    input  logic                                          rst,
    input  sat_pkg::cmd_t                                 cmd_i,
    input  sat_pkg::load_t                                load_i,
    input  logic                                          unit_valid_i,
    input  logic [sat_pkg::idx_w-1:0]                     unit_index_i,
    input  logic                                          unit_value_i,
    output sat_pkg::var_state_t [sat_pkg::num_vars-1:0]   vars_o,
    output logic [sat_pkg::lvl_w-1:0]                     cur_lvl_o,
    output logic                                          no_free_var_o
);

    logic [sat_pkg::num_vars-1:0] free_mask;
    logic                         any_free;
    logic [sat_pkg::idx_w-1:0]    free_idx;
    logic [sat_pkg::lvl_w-1:0]    next_lvl;
    logic                         do_decide;
    logic                         do_imply;
    logic                         do_bkt;

    assign do_decide = cmd_i.valid & (cmd_i.op == sat_pkg::op_decide);
    assign do_imply  = cmd_i.valid & (cmd_i.op == sat_pkg::op_imply);
    assign do_bkt    = cmd_i.valid & (cmd_i.op == sat_pkg::op_backtrack);
    assign next_lvl  = cur_lvl_o + 1'b1;
    assign any_free  = |free_mask;

    // lowest unassigned index wins
    always_comb begin
        free_idx = '0;
        for (int i = sat_pkg::num_vars - 1; i >= 0; i--) begin
            free_mask[i] = ~vars_o[i].assigned;
            if (free_mask[i]) begin
                free_idx = i[sat_pkg::idx_w-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            vars_o        <= '0;
            cur_lvl_o     <= '0;
            no_free_var_o <= 1'b0;
        end else begin
            if (load_i.base_we) begin
                cur_lvl_o <= load_i.base_data;
            end

            if (do_decide) begin
                no_free_var_o <= ~any_free;
                if (any_free) begin
                    cur_lvl_o <= next_lvl;
                    vars_o[free_idx] <= '{assigned: 1'b1, value: 1'b0,
                                          decided: 1'b1, lvl: next_lvl};
                end
            end

            // implied value goes in at the current level
            if (do_imply && unit_valid_i) begin
                vars_o[unit_index_i] <= '{assigned: 1'b1, value: unit_value_i,
                                          decided: 1'b0, lvl: cur_lvl_o};
            end

            if (do_bkt) begin
                cur_lvl_o <= cmd_i.arg_lvl;
                for (int i = 0; i < sat_pkg::num_vars; i++) begin
                    if (vars_o[i].lvl > cmd_i.arg_lvl) begin
                        vars_o[i] <= '0;
                    end
                end
            end

            // host writes take priority
            for (int i = 0; i < sat_pkg::num_vars; i++) begin
                if (load_i.var_we[i]) begin
                    vars_o[i] <= load_i.var_data;
                end
            end
        end
    end

endmodule

//--- source/clause_eval.sv
`timescale 1ns/1ps

module clause_eval (
    input  logic                                        clk,
    input  logic                                        rst,
    input  sat_pkg::clause_t                            clause_i,
    input  sat_pkg::load_t                              load_i,
    input  sat_pkg::var_state_t [sat_pkg::num_vars-1:0] vars_i,
    input  logic [sat_pkg::lvl_w-1:0]                   cur_lvl_i,
    input  logic [sat_pkg::lvl_w-1:0]                   base_lvl_i,
    output logic                                        unit_valid_o,
    output logic [sat_pkg::idx_w-1:0]                   unit_index_o,
    output logic                                        unit_value_o,
    output logic                                        conflict_o,
    output logic [sat_pkg::lvl_w-1:0]                   bkt_lvl_o
);

    sat_pkg::clause_t             clause_q;
    logic [sat_pkg::lvl_w-1:0]    base_q;
    logic [sat_pkg::num_vars-1:0] lit_true;
    logic [sat_pkg::num_vars-1:0] lit_false;
    logic [sat_pkg::num_vars-1:0] lit_free;
    logic [sat_pkg::idx_w:0]      free_cnt;
    logic [sat_pkg::lvl_w-1:0]    max_lvl;
    logic                         max_found;

    always_ff @(posedge clk) begin
        if (!rst) begin
            clause_q <= '0;
            base_q   <= '0;
        end else begin
            if (load_i.clause_we) begin
                clause_q <= clause_i;
            end
            if (load_i.base_we) begin
                base_q <= base_lvl_i;
            end
        end
    end

    always_comb begin
        free_cnt     = '0;
        unit_index_o = '0;
        max_lvl      = '0;
        max_found    = 1'b0;
        for (int i = 0; i < sat_pkg::num_vars; i++) begin
            lit_true[i]  = clause_q.lit_mask[i] & vars_i[i].assigned &
                           (vars_i[i].value == clause_q.lit_pol[i]);
            lit_false[i] = clause_q.lit_mask[i] & vars_i[i].assigned &
                           (vars_i[i].value != clause_q.lit_pol[i]);
            lit_free[i]  = clause_q.lit_mask[i] & ~vars_i[i].assigned;
            if (lit_free[i]) begin
                free_cnt     = free_cnt + 1'b1;
                unit_index_o = i[sat_pkg::idx_w-1:0];
            end
            // deepest level still below the current one
            if (clause_q.lit_mask[i] && vars_i[i].assigned && (vars_i[i].lvl < cur_lvl_i) &&
                (!max_found || (vars_i[i].lvl > max_lvl))) begin
                max_lvl   = vars_i[i].lvl;
                max_found = 1'b1;
            end
        end
    end

    assign unit_valid_o = (free_cnt == 1) & ~|lit_true;
    assign unit_value_o = clause_q.lit_pol[unit_index_o];
    assign conflict_o   = (lit_false == clause_q.lit_mask);
    assign bkt_lvl_o    = max_found ? max_lvl : base_q;

endmodule

//--- source/engine_result.sv
`timescale 1ns/1ps

module engine_result (
    input  logic                                        clk,
    input  logic                                        rst,
    input  sat_pkg::apb_req_t                           apb_i,
    input  logic                                        wr_ack_i,
    input  logic                                        wr_err_i,
    input  sat_pkg::cmd_t                               cmd_i,
    input  sat_pkg::var_state_t [sat_pkg::num_vars-1:0] vars_i,
    input  logic [sat_pkg::lvl_w-1:0]                   cur_lvl_i,
    input  logic                                        no_free_var_i,
    input  logic                                        unit_valid_i,
    input  logic                                        conflict_i,
    input  logic [sat_pkg::lvl_w-1:0]                   bkt_lvl_i,
    output sat_pkg::apb_rsp_t                           apb_o
);

    logic [3:0]                done_q;
    logic                      conflict_q;
    logic                      imply_found_q;
    logic [sat_pkg::lvl_w-1:0] bkt_q;
    logic                      rd_first;
    logic                      rd_ack_q;
    logic                      rd_err_q;
    logic [31:0]               rd_word;
    logic [31:0]               prdata_q;
    sat_pkg::status_t          status;

    // one done bit per opcode
    always_ff @(posedge clk) begin
        if (!rst) begin
            done_q        <= '0;
            conflict_q    <= 1'b0;
            imply_found_q <= 1'b0;
            bkt_q         <= '0;
        end else if (cmd_i.valid) begin
            done_q <= 4'b0001 << cmd_i.op;
            case (cmd_i.op)
                sat_pkg::op_imply: begin
                    conflict_q    <= conflict_i;
                    imply_found_q <= unit_valid_i;
                end
                sat_pkg::op_analyze: bkt_q <= bkt_lvl_i;
                sat_pkg::op_backtrack: conflict_q <= 1'b0;
                default: ;
            endcase
        end
    end

    always_comb begin
        status                = '0;
        status.cur_lvl        = cur_lvl_i;
        status.bkt_lvl        = bkt_q;
        status.conflict       = conflict_q;
        status.no_free_var    = no_free_var_i;
        status.done_decide    = done_q[sat_pkg::op_decide];
        status.done_imply     = done_q[sat_pkg::op_imply];
        status.done_analyze   = done_q[sat_pkg::op_analyze];
        status.done_backtrack = done_q[sat_pkg::op_backtrack];
        status.imply_found    = imply_found_q;

        // write-only registers read back as zero
        rd_word = '0;
        if (apb_i.paddr == sat_pkg::addr_status) begin
            rd_word = status;
        end else if (sat_pkg::is_var_addr(apb_i.paddr)) begin
            rd_word = 32'(vars_i[sat_pkg::var_sel(apb_i.paddr)]);
        end
    end

    // first read access cycle, pready follows one cycle later
    assign rd_first = apb_i.psel & apb_i.penable & ~apb_i.pwrite & ~rd_ack_q;

    always_ff @(posedge clk) begin
        if (!rst) begin
            rd_ack_q <= 1'b0;
            rd_err_q <= 1'b0;
        end else begin
            rd_ack_q <= rd_first;
            rd_err_q <= rd_first & ~sat_pkg::addr_mapped(apb_i.paddr);
        end
    end

    always_ff @(posedge clk) begin
        if (rd_first) begin
            prdata_q <= rd_word;
        end
    end

    assign apb_o = '{prdata: prdata_q,
                     pready: rd_ack_q | wr_ack_i,
                     pslverr: rd_err_q | wr_err_i};

endmodule

//--- source/sat_state_top.sv
`timescale 1ns/1ps

module sat_state_top (
    input  logic              clk,
    input  logic              rst,
    input  sat_pkg::apb_req_t apb_i,
    output sat_pkg::apb_rsp_t apb_o
);

    sat_pkg::cmd_t                               cmd;
    sat_pkg::load_t                              load;
    logic                                        wr_ack;
    logic                                        wr_err;
    sat_pkg::var_state_t [sat_pkg::num_vars-1:0] vars;
    logic [sat_pkg::lvl_w-1:0]                   cur_lvl;
    logic [sat_pkg::lvl_w-1:0]                   bkt_lvl;
    logic                                        no_free_var;
    logic                                        unit_valid;
    logic [sat_pkg::idx_w-1:0]                   unit_index;
    logic                                        unit_value;
    logic                                        conflict;

    apb_cmd_decode i_decode (
        .clk      (clk),
        .rst      (rst),
        .apb_i    (apb_i),
        .cmd_o    (cmd),
        .load_o   (load),
        .wr_ack_o (wr_ack),
        .wr_err_o (wr_err)
    );

    var_state_bank i_bank (
        .clk           (clk),
        .rst           (rst),
        .cmd_i         (cmd),
        .load_i        (load),
        .unit_valid_i  (unit_valid),
        .unit_index_i  (unit_index),
        .unit_value_i  (unit_value),
        .vars_o        (vars),
        .cur_lvl_o     (cur_lvl),
        .no_free_var_o (no_free_var)
    );

    // clause and base level data ride on the load bus
    clause_eval i_eval (
        .clk          (clk),
        .rst          (rst),
        .clause_i     (load.clause_data),
        .load_i       (load),
        .vars_i       (vars),
        .cur_lvl_i    (cur_lvl),
        .base_lvl_i   (load.base_data),
        .unit_valid_o (unit_valid),
        .unit_index_o (unit_index),
        .unit_value_o (unit_value),
        .conflict_o   (conflict),
        .bkt_lvl_o    (bkt_lvl)
    );

    engine_result i_result (
        .clk           (clk),
        .rst           (rst),
        .apb_i         (apb_i),
        .wr_ack_i      (wr_ack),
        .wr_err_i      (wr_err),
        .cmd_i         (cmd),
        .vars_i        (vars),
        .cur_lvl_i     (cur_lvl),
        .no_free_var_i (no_free_var),
        .unit_valid_i  (unit_valid),
        .conflict_i    (conflict),
        .bkt_lvl_i     (bkt_lvl),
        .apb_o         (apb_o)
    );

endmodule

//--- verif/sat_model_checker.sv
`timescale 1ns/1ps

module sat_model_checker (
    input  logic              clk,
    input  logic              rst,
    input  sat_pkg::apb_req_t apb_req_i,
    input  sat_pkg::apb_rsp_t apb_rsp_i,
    output int                err_cnt_o,
    output int                rd_cnt_o
);

    sat_pkg::var_state_t m_vars [sat_pkg::num_vars];
    sat_pkg::clause_t    m_clause;
    logic [7:0]          m_cur;
    logic [7:0]          m_base;
    logic [7:0]          m_bkt;
    logic [3:0]          m_done;
    logic                m_conflict;
    logic                m_no_free;
    logic                m_found;
    int                  acc_cnt;

    function automatic logic is_var(logic [7:0] a);
        return (a >= sat_pkg::addr_var_base) && (a < sat_pkg::addr_var_base + 8'd32) &&
               (a[1:0] == 2'b00);
    endfunction

    function automatic int var_index(logic [7:0] a);
        return int'(a - sat_pkg::addr_var_base) / 4;
    endfunction

    function automatic logic exp_err(logic [7:0] a, logic wr);
        logic mapped;
        mapped = (a == sat_pkg::addr_cmd) || (a == sat_pkg::addr_base_lvl) ||
                 (a == sat_pkg::addr_clause) || (a == sat_pkg::addr_status) || is_var(a);
        return !mapped || (wr && (a == sat_pkg::addr_status));
    endfunction

    task automatic compare_field(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (exp !== act) begin
            $display("error at time %0t: %s expected %0h got %0h", $time, name, exp, act);
            err_cnt_o++;
        end
    endtask

    task automatic model_reset();
        for (int i = 0; i < sat_pkg::num_vars; i++) begin
            m_vars[i] = '0;
        end
        m_clause   = '0;
        m_cur      = '0;
        m_base     = '0;
        m_bkt      = '0;
        m_done     = '0;
        m_conflict = 1'b0;
        m_no_free  = 1'b0;
        m_found    = 1'b0;
        acc_cnt    = 0;
        err_cnt_o  = 0;
        rd_cnt_o   = 0;
    endtask

    task automatic apply_cmd(input logic [1:0] op, input logic [7:0] arg);
        int         idx;
        int         n_free;
        logic       any_true;
        logic       all_false;
        logic       have;
        logic [7:0] best;
        idx       = -1;
        n_free    = 0;
        any_true  = 1'b0;
        all_false = 1'b1;
        have      = 1'b0;
        best      = '0;
        m_done      = '0;
        m_done[op]  = 1'b1;
        case (op)
            sat_pkg::op_decide: begin
                for (int i = 0; i < sat_pkg::num_vars; i++) begin
                    if (idx < 0 && !m_vars[i].assigned) idx = i;
                end
                m_no_free = (idx < 0);
                if (idx >= 0) begin
                    m_cur = m_cur + 8'd1;
                    m_vars[idx] = '{1'b1, 1'b0, 1'b1, m_cur};
                end
            end
            sat_pkg::op_imply: begin
                for (int i = 0; i < sat_pkg::num_vars; i++) begin
                    if (m_clause.lit_mask[i] && !m_vars[i].assigned) begin
                        n_free++;
                        idx = i;
                        all_false = 1'b0;
                    end else if (m_clause.lit_mask[i] &&
                                 m_vars[i].value == m_clause.lit_pol[i]) begin
                        any_true  = 1'b1;
                        all_false = 1'b0;
                    end
                end
                m_conflict = all_false;
                m_found    = (n_free == 1) && !any_true;
                if (m_found) m_vars[idx] = '{1'b1, m_clause.lit_pol[idx], 1'b0, m_cur};
            end
            sat_pkg::op_analyze: begin
                for (int i = 0; i < sat_pkg::num_vars; i++) begin
                    if (m_clause.lit_mask[i] && m_vars[i].assigned && m_vars[i].lvl < m_cur &&
                        (!have || m_vars[i].lvl > best)) begin
                        best = m_vars[i].lvl;
                        have = 1'b1;
                    end
                end
                m_bkt = have ? best : m_base;
            end
            default: begin
                for (int i = 0; i < sat_pkg::num_vars; i++) begin
                    if (m_vars[i].lvl > arg) m_vars[i] = '0;
                end
                m_cur      = arg;
                m_conflict = 1'b0;
            end
        endcase
    endtask

    task automatic apply_write(input logic [7:0] a, input logic [31:0] d);
        if (a == sat_pkg::addr_cmd) begin
            apply_cmd(d[9:8], d[7:0]);
        end else if (a == sat_pkg::addr_base_lvl) begin
            m_base = d[7:0];
            m_cur  = d[7:0];
        end else if (a == sat_pkg::addr_clause) begin
            m_clause = d[15:0];
        end else if (is_var(a)) begin
            m_vars[var_index(a)] = d[10:0];
        end
    endtask

    task automatic compare_read(input logic [7:0] a, input logic [31:0] d, input logic err);
        sat_pkg::status_t    act;
        sat_pkg::var_state_t av;
        sat_pkg::var_state_t ev;
        string               tag;
        act = d;
        av  = d[10:0];
        rd_cnt_o++;
        compare_field("pslverr", exp_err(a, 1'b0), err);
        if (a == sat_pkg::addr_status) begin
            compare_field("status.rsvd", 0, act.rsvd);
            compare_field("status.cur_lvl", m_cur, act.cur_lvl);
            compare_field("status.bkt_lvl", m_bkt, act.bkt_lvl);
            compare_field("status.conflict", m_conflict, act.conflict);
            compare_field("status.no_free_var", m_no_free, act.no_free_var);
            compare_field("status.done_decide", m_done[0], act.done_decide);
            compare_field("status.done_imply", m_done[1], act.done_imply);
            compare_field("status.done_analyze", m_done[2], act.done_analyze);
            compare_field("status.done_backtrack", m_done[3], act.done_backtrack);
            compare_field("status.imply_found", m_found, act.imply_found);
        end else if (is_var(a)) begin
            ev  = m_vars[var_index(a)];
            tag = $sformatf("var%0d", var_index(a));
            compare_field({tag, ".rsvd"}, 0, d[31:11]);
            compare_field({tag, ".assigned"}, ev.assigned, av.assigned);
            compare_field({tag, ".value"}, ev.value, av.value);
            compare_field({tag, ".decided"}, ev.decided, av.decided);
            compare_field({tag, ".lvl"}, ev.lvl, av.lvl);
        end else begin
            compare_field("prdata", 0, d);
        end
    endtask

    // transfers complete when pready is seen in an access cycle
    // writes finish in one access cycle, reads in two
    always @(negedge clk) begin
        if (!rst) begin
            model_reset();
        end else if (apb_req_i.psel && apb_req_i.penable) begin
            acc_cnt++;
            if (apb_rsp_i.pready) begin
                compare_field("access_cycles", apb_req_i.pwrite ? 1 : 2, acc_cnt);
                acc_cnt = 0;
                if (apb_req_i.pwrite) begin
                    compare_field("pslverr", exp_err(apb_req_i.paddr, 1'b1),
                                  apb_rsp_i.pslverr);
                    if (!exp_err(apb_req_i.paddr, 1'b1)) begin
                        apply_write(apb_req_i.paddr, apb_req_i.pwdata);
                    end
                end else begin
                    compare_read(apb_req_i.paddr, apb_rsp_i.prdata, apb_rsp_i.pslverr);
                end
            end
        end else begin
            acc_cnt = 0;
        end
    end

endmodule

//--- verif/tb_top.sv
`timescale 1ns/1ps

module tb_top;

    logic              clk;
    logic              rst;
    sat_pkg::apb_req_t apb_req;
    sat_pkg::apb_rsp_t apb_rsp;
    logic [31:0]       lcg_state;
    int                err_cnt;
    int                rd_cnt;
    int                test_no;
    int                last_err;
    int                last_rd;
    int                sel;
    logic [7:0]        mask;
    logic [7:0]        pol;

    sat_state_top i_dut (
        .clk   (clk),
        .rst   (rst),
        .apb_i (apb_req),
        .apb_o (apb_rsp)
    );

    sat_model_checker i_chk (
        .clk       (clk),
        .rst       (rst),
        .apb_req_i (apb_req),
        .apb_rsp_i (apb_rsp),
        .err_cnt_o (err_cnt),
        .rd_cnt_o  (rd_cnt)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic int pick(int n);
        logic [31:0] r;
        r = lcg_next();
        return int'(r[30:16]) % n;
    endfunction

    // ends the transfer one edge after pready
    task automatic wait_ready(input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (apb_rsp.pready !== 1'b1 && n < 20) begin
            n++;
            @(negedge clk);
        end
        if (apb_rsp.pready !== 1'b1) begin
            $display("timeout: pready never rose during %s", what);
            $display("Regression failed");
            $finish;
        end else begin
            @(posedge clk);
            #1;
            apb_req = '0;
        end
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        wait_ready($sformatf("write to %h", addr));
    endtask

    task automatic fetch_reg(input logic [7:0] addr);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'h0};
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        wait_ready($sformatf("read of %h", addr));
    endtask

    task automatic issue_cmd(input logic [1:0] op, input logic [7:0] arg);
        write_reg(sat_pkg::addr_cmd, {22'b0, op, arg});
    endtask

    // word layout is assigned, value, decided, lvl
    task automatic load_var(input int idx, input logic a, input logic v, input logic d,
                            input logic [7:0] lvl);
        write_reg(sat_pkg::addr_var_base + 8'(4 * idx), {21'b0, a, v, d, lvl});
    endtask

    task automatic readback_all();
        fetch_reg(sat_pkg::addr_status);
        for (int i = 0; i < sat_pkg::num_vars; i++) begin
            fetch_reg(sat_pkg::addr_var_base + 8'(4 * i));
        end
    endtask

    task automatic clear_state();
        write_reg(sat_pkg::addr_base_lvl, 32'h0);
        for (int i = 0; i < sat_pkg::num_vars; i++) begin
            load_var(i, 1'b0, 1'b0, 1'b0, 8'h0);
        end
    endtask

    task automatic end_test(input string name);
        test_no++;
        $display("test %0d %s: %0d reads, %0d errors", test_no, name,
                 rd_cnt - last_rd, err_cnt - last_err);
        last_rd  = rd_cnt;
        last_err = err_cnt;
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b0;
        apb_req   = '0;
        lcg_state = 32'd49145;
        test_no   = 0;
        last_err  = 0;
        last_rd   = 0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b1;

        readback_all();
        fetch_reg(sat_pkg::addr_cmd);
        fetch_reg(8'h30);
        fetch_reg(8'h11);
        write_reg(8'h44, lcg_next());
        write_reg(sat_pkg::addr_status, lcg_next());
        readback_all();
        end_test("reset_and_errors");

        clear_state();
        repeat (9) begin
            issue_cmd(sat_pkg::op_decide, 8'h0);
            readback_all();
        end
        end_test("decide_sequence");

        // mostly false literals so units and conflicts show up
        repeat (40) begin
            mask = 8'(lcg_next() >> 8);
            pol  = 8'(lcg_next() >> 8);
            write_reg(sat_pkg::addr_clause, {16'b0, mask, pol});
            for (int i = 0; i < sat_pkg::num_vars; i++) begin
                sel = pick(4);
                if (sel == 0) begin
                    load_var(i, 1'b0, 1'b0, 1'b0, 8'(pick(8)));
                end else if (sel == 3) begin
                    load_var(i, 1'b1, 1'(pick(2)), 1'(pick(2)), 8'(pick(8)));
                end else begin
                    load_var(i, 1'b1, ~pol[i], 1'b0, 8'(pick(8)));
                end
            end
            issue_cmd(sat_pkg::op_imply, 8'h0);
            readback_all();
        end
        end_test("imply_random");

        repeat (30) begin
            mask = 8'(lcg_next() >> 8) | 8'h01;
            pol  = 8'(lcg_next() >> 8);
            write_reg(sat_pkg::addr_clause, {16'b0, mask, pol});
            for (int i = 0; i < sat_pkg::num_vars; i++) begin
                if (mask[i]) begin
                    load_var(i, 1'b1, ~pol[i], 1'(pick(2)), 8'(pick(8)));
                end else begin
                    load_var(i, 1'b0, 1'b0, 1'b0, 8'h0);
                end
            end
            write_reg(sat_pkg::addr_base_lvl, 32'(pick(8)));
            repeat (pick(3)) issue_cmd(sat_pkg::op_decide, 8'h0);
            issue_cmd(sat_pkg::op_imply, 8'h0);
            issue_cmd(sat_pkg::op_analyze, 8'h0);
            fetch_reg(sat_pkg::addr_status);
        end
        end_test("analyze_after_conflict");

        repeat (30) begin
            for (int i = 0; i < sat_pkg::num_vars; i++) begin
                load_var(i, 1'b1, 1'(pick(2)), 1'(pick(2)), 8'(pick(10)));
            end
            write_reg(sat_pkg::addr_base_lvl, 32'(pick(10)));
            issue_cmd(sat_pkg::op_backtrack, 8'(pick(10)));
            readback_all();
        end
        end_test("backtrack_random");

        repeat (300) begin
            sel = pick(7);
            if (sel < 4) begin
                issue_cmd(2'(sel), 8'(pick(10)));
            end else if (sel == 4) begin
                load_var(pick(8), 1'(pick(2)), 1'(pick(2)), 1'(pick(2)), 8'(pick(10)));
            end else if (sel == 5) begin
                write_reg(sat_pkg::addr_clause, {16'b0, 16'(lcg_next() >> 8)});
            end else begin
                write_reg(sat_pkg::addr_base_lvl, 32'(pick(6)));
            end
            readback_all();
        end
        end_test("random_mix");

        $display("%0d tests, %0d reads checked, %0d errors", test_no, rd_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- sim.f
source/sat_pkg.sv
source/apb_cmd_decode.sv
source/var_state_bank.sv
source/clause_eval.sv
source/engine_result.sv
source/sat_state_top.sv
verif/sat_model_checker.sv
verif/tb_top.sv
